/* source/agu_cfg_pkg.sv */
package agu_cfg_pkg;

   localparam int ADDR_W   = 10;
   localparam int PERIOD_W = 10;
   localparam int DELAY_W  = 7;
   localparam int DATA_W   = 32;
   // addresses are byte addresses, so every step is scaled to whole words.
   localparam int OFFSET_W = $clog2(DATA_W / 8);
   localparam int NUM_LVL  = 3;

   typedef struct packed {
      logic        [PERIOD_W-1:0] period;
      logic signed [ADDR_W-1:0]   incr;
      logic        [ADDR_W-1:0]   iterations;
      logic signed [ADDR_W-1:0]   shift;
   } agu_level_t;

   // lvl[0] is the innermost loop level.
   typedef struct packed {
      logic       [ADDR_W-1:0]   start;
      logic       [PERIOD_W-1:0] duty;
      agu_level_t [NUM_LVL-1:0]  lvl;
      logic       [DELAY_W-1:0]  delay;
   } agu_cfg_t;

   // a level field code is FLD_LVL_BASE + 4 * level + one of the sub codes.
   localparam int CFG_FIELD_W = 4;
   localparam logic [CFG_FIELD_W-1:0] FLD_START    = 4'd0;
   localparam logic [CFG_FIELD_W-1:0] FLD_DUTY     = 4'd1;
   localparam logic [CFG_FIELD_W-1:0] FLD_DELAY    = 4'd2;
   localparam logic [CFG_FIELD_W-1:0] FLD_LVL_BASE = 4'd3;
   localparam logic [1:0] FLD_PERIOD = 2'd0;
   localparam logic [1:0] FLD_INCR   = 2'd1;
   localparam logic [1:0] FLD_ITER   = 2'd2;
   localparam logic [1:0] FLD_SHIFT  = 2'd3;

endpackage

/* source/agu_port_pkg.sv */
package agu_port_pkg;

   import agu_cfg_pkg::*;

   localparam int NUM_CH = 2;

   typedef logic [$clog2(NUM_CH)-1:0] agu_ch_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              store;
   } agu_beat_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              store;
      agu_ch_t           ch;
   } agu_req_t;

endpackage

/* source/agu_config_regs.sv */
`timescale 1ns/1ps

module agu_config_regs import agu_cfg_pkg::*, agu_port_pkg::*; (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         cfg_we_i,
   input  agu_ch_t                      cfg_ch_i,
   input  logic [CFG_FIELD_W-1:0]       cfg_field_i,
   input  logic [31:0]                  cfg_data_i,
   input  logic                         cfg_run_i,
   input  logic [NUM_CH-1:0]            cfg_run_mask_i,
   output agu_cfg_t [NUM_CH-1:0]        cfg_o,
   output logic [NUM_CH-1:0]            run_o
);

   agu_cfg_t [NUM_CH-1:0]    cfg_q;
   logic [NUM_CH-1:0]        run_q;
   logic [CFG_FIELD_W-1:0]   lvl_code;
   logic [CFG_FIELD_W-3:0]   lvl_idx;
   logic [1:0]               lvl_sub;
   logic                     lvl_hit;

   // split a level field code into the level number and the field inside it.
   assign lvl_code = cfg_field_i - FLD_LVL_BASE;
   assign lvl_idx  = lvl_code[CFG_FIELD_W-1:2];
   assign lvl_sub  = lvl_code[1:0];
   assign lvl_hit  = (cfg_field_i >= FLD_LVL_BASE) && (int'(lvl_idx) < NUM_LVL);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cfg_q <= '0;
      end else if (cfg_we_i) begin
         if (cfg_field_i == FLD_START) begin
            cfg_q[cfg_ch_i].start <= cfg_data_i[ADDR_W-1:0];
         end else if (cfg_field_i == FLD_DUTY) begin
            cfg_q[cfg_ch_i].duty <= cfg_data_i[PERIOD_W-1:0];
         end else if (cfg_field_i == FLD_DELAY) begin
            cfg_q[cfg_ch_i].delay <= cfg_data_i[DELAY_W-1:0];
         end else if (lvl_hit) begin
            case (lvl_sub)
               FLD_PERIOD: cfg_q[cfg_ch_i].lvl[lvl_idx].period <= cfg_data_i[PERIOD_W-1:0];
               FLD_INCR:   cfg_q[cfg_ch_i].lvl[lvl_idx].incr <= cfg_data_i[ADDR_W-1:0];
               FLD_ITER:   cfg_q[cfg_ch_i].lvl[lvl_idx].iterations <= cfg_data_i[ADDR_W-1:0];
               default:    cfg_q[cfg_ch_i].lvl[lvl_idx].shift <= cfg_data_i[ADDR_W-1:0];
            endcase
         end
      end
   end

   // the run pulse is registered so it lines up with a settled configuration.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         run_q <= '0;
      end else begin
         run_q <= cfg_run_i ? cfg_run_mask_i : '0;
      end
   end

   assign cfg_o = cfg_q;
   assign run_o = run_q;

endmodule

/* source/agu_channel.sv */
`timescale 1ns/1ps

module agu_channel import agu_cfg_pkg::*, agu_port_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      run_i,
   input  agu_cfg_t  cfg_i,
   input  logic      ready_i,
   output logic      valid_o,
   output agu_beat_t beat_o,
   output logic      done_o
);

   agu_cfg_t             cfg_q;
   logic [DELAY_W-1:0]   delay_cnt;
   logic [PERIOD_W-1:0]  per_q  [NUM_LVL];
   logic [ADDR_W-1:0]    iter_q [NUM_LVL];
   logic [ADDR_W-1:0]    addr_q;
   logic [ADDR_W-1:0]    base1_q;
   logic [ADDR_W-1:0]    base2_q;
   logic                 valid_q;
   logic                 done_q;
   logic [NUM_LVL-1:0]   per_end;
   logic [NUM_LVL-1:0]   iter_end;
   logic [5:0]           ends;
   logic                 store_w;

   function automatic logic [ADDR_W-1:0] step(input logic [ADDR_W-1:0] base,
                                              input logic signed [ADDR_W-1:0] delta);
      return base + (delta << OFFSET_W);
   endfunction

   // a level ends on its last count, or at once when its limit is zero.
   always_comb begin
      for (int l = 0; l < NUM_LVL; l++) begin
         per_end[l]  = (per_q[l] + 1'b1 == cfg_q.lvl[l].period) ||
                       (cfg_q.lvl[l].period == '0);
         iter_end[l] = (iter_q[l] + 1'b1 == cfg_q.lvl[l].iterations) ||
                       (cfg_q.lvl[l].iterations == '0);
      end
   end

   assign ends    = {iter_end[2], per_end[2], iter_end[1], per_end[1], iter_end[0], per_end[0]};
   assign store_w = (per_q[0] < cfg_q.duty);

   // the configuration is only taken on a run pulse.
   always_ff @(posedge clk_i) begin
      if (run_i) begin
         cfg_q <= cfg_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         delay_cnt <= '0;
         addr_q    <= '0;
         base1_q   <= '0;
         base2_q   <= '0;
         valid_q   <= 1'b0;
         done_q    <= 1'b1;
         for (int l = 0; l < NUM_LVL; l++) begin
            per_q[l]  <= '0;
            iter_q[l] <= '0;
         end
      end else if (run_i) begin
         // a zero delay still costs one cycle before the first beat.
         delay_cnt <= (cfg_i.delay == '0) ? DELAY_W'(1) : cfg_i.delay;
         addr_q    <= cfg_i.start;
         base1_q   <= cfg_i.start;
         base2_q   <= cfg_i.start;
         valid_q   <= 1'b0;
         done_q    <= 1'b0;
         for (int l = 0; l < NUM_LVL; l++) begin
            per_q[l]  <= '0;
            iter_q[l] <= '0;
         end
      end else if (delay_cnt != '0) begin
         delay_cnt <= delay_cnt - 1'b1;
         valid_q   <= (delay_cnt == DELAY_W'(1));
      end else if (valid_q && ready_i) begin
         casez (ends)
            6'b?????0: begin
               if (store_w) begin
                  addr_q <= step(addr_q, cfg_q.lvl[0].incr);
               end
               per_q[0] <= per_q[0] + 1'b1;
            end
            6'b????01: begin
               addr_q    <= step(addr_q, cfg_q.lvl[0].shift);
               per_q[0]  <= '0;
               iter_q[0] <= iter_q[0] + 1'b1;
            end
            6'b???011: begin
               addr_q    <= step(base1_q, cfg_q.lvl[1].incr);
               base1_q   <= step(base1_q, cfg_q.lvl[1].incr);
               per_q[0]  <= '0;
               iter_q[0] <= '0;
               per_q[1]  <= per_q[1] + 1'b1;
            end
            6'b??0111: begin
               addr_q    <= step(base1_q, cfg_q.lvl[1].shift);
               base1_q   <= step(base1_q, cfg_q.lvl[1].shift);
               per_q[0]  <= '0;
               iter_q[0] <= '0;
               per_q[1]  <= '0;
               iter_q[1] <= iter_q[1] + 1'b1;
            end
            6'b?01111: begin
               // the outermost base also reloads the middle base.
               addr_q    <= step(base2_q, cfg_q.lvl[2].incr);
               base1_q   <= step(base2_q, cfg_q.lvl[2].incr);
               base2_q   <= step(base2_q, cfg_q.lvl[2].incr);
               per_q[0]  <= '0;
               iter_q[0] <= '0;
               per_q[1]  <= '0;
               iter_q[1] <= '0;
               per_q[2]  <= per_q[2] + 1'b1;
            end
            6'b011111: begin
               addr_q    <= step(base2_q, cfg_q.lvl[2].shift);
               base1_q   <= step(base2_q, cfg_q.lvl[2].shift);
               base2_q   <= step(base2_q, cfg_q.lvl[2].shift);
               per_q[0]  <= '0;
               iter_q[0] <= '0;
               per_q[1]  <= '0;
               iter_q[1] <= '0;
               per_q[2]  <= '0;
               iter_q[2] <= iter_q[2] + 1'b1;
            end
            default: begin
               // every level has ended, so this was the last beat.
               valid_q <= 1'b0;
               done_q  <= 1'b1;
            end
         endcase
      end
   end

   assign valid_o      = valid_q;
   assign done_o       = done_q;
   assign beat_o.addr  = addr_q;
   assign beat_o.store = store_w;

endmodule

/* source/agu_merger.sv */
`timescale 1ns/1ps

module agu_merger import agu_port_pkg::*; (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic [NUM_CH-1:0]       ch_valid_i,
   input  agu_beat_t [NUM_CH-1:0]  ch_beat_i,
   input  logic                    mem_ready_i,
   output logic [NUM_CH-1:0]       ch_ready_o,
   output logic                    mem_valid_o,
   output agu_req_t                mem_req_o
);

   agu_ch_t ptr_q;
   agu_ch_t sel;

   // walk down from the farthest offset so the channel nearest the pointer wins.
   always_comb begin
      int unsigned idx;
      sel = ptr_q;
      for (int i = NUM_CH - 1; i >= 0; i--) begin
         idx = (int'(ptr_q) + i) % NUM_CH;
         if (ch_valid_i[idx]) begin
            sel = agu_ch_t'(idx);
         end
      end
   end

   assign mem_valid_o = |ch_valid_i;

   // only the selected channel sees the port's ready.
   always_comb begin
      ch_ready_o      = '0;
      ch_ready_o[sel] = mem_ready_i;
   end

   assign mem_req_o.addr  = ch_beat_i[sel].addr;
   assign mem_req_o.store = ch_beat_i[sel].store;
   assign mem_req_o.ch    = sel;

   // the pointer moves just past the channel that has transferred.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ptr_q <= '0;
      end else if (mem_valid_o && mem_ready_i) begin
         ptr_q <= agu_ch_t'((int'(sel) + 1) % NUM_CH);
      end
   end

endmodule

/* source/agu_top.sv */
`timescale 1ns/1ps

module agu_top import agu_cfg_pkg::*, agu_port_pkg::*; (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    cfg_we_i,
   input  agu_ch_t                 cfg_ch_i,
   input  logic [CFG_FIELD_W-1:0]  cfg_field_i,
   input  logic [31:0]             cfg_data_i,
   input  logic                    cfg_run_i,
   input  logic [NUM_CH-1:0]       cfg_run_mask_i,
   input  logic                    mem_ready_i,
   output logic                    mem_valid_o,
   output agu_req_t                mem_req_o,
   output logic [NUM_CH-1:0]       done_o
);

   agu_cfg_t [NUM_CH-1:0]   ch_cfg;
   logic [NUM_CH-1:0]       ch_run;
   logic [NUM_CH-1:0]       ch_valid;
   logic [NUM_CH-1:0]       ch_ready;
   agu_beat_t [NUM_CH-1:0]  ch_beat;

   agu_config_regs u_cfg (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cfg_we_i       (cfg_we_i),
      .cfg_ch_i       (cfg_ch_i),
      .cfg_field_i    (cfg_field_i),
      .cfg_data_i     (cfg_data_i),
      .cfg_run_i      (cfg_run_i),
      .cfg_run_mask_i (cfg_run_mask_i),
      .cfg_o          (ch_cfg),
      .run_o          (ch_run)
   );

   for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
      agu_channel u_ch (
         .clk_i   (clk_i),
         .rst_i   (rst_i),
         .run_i   (ch_run[c]),
         .cfg_i   (ch_cfg[c]),
         .ready_i (ch_ready[c]),
         .valid_o (ch_valid[c]),
         .beat_o  (ch_beat[c]),
         .done_o  (done_o[c])
      );
   end

   agu_merger u_merge (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ch_valid_i  (ch_valid),
      .ch_beat_i   (ch_beat),
      .mem_ready_i (mem_ready_i),
      .ch_ready_o  (ch_ready),
      .mem_valid_o (mem_valid_o),
      .mem_req_o   (mem_req_o)
   );

endmodule

/* tb/agu_tb.sv */
`timescale 1ns/1ps

module agu_tb import agu_cfg_pkg::*, agu_port_pkg::*; ();

   logic                    clk_i;
   logic                    rst_i;
   logic                    cfg_we_i;
   agu_ch_t                 cfg_ch_i;
   logic [CFG_FIELD_W-1:0]  cfg_field_i;
   logic [31:0]             cfg_data_i;
   logic                    cfg_run_i;
   logic [NUM_CH-1:0]       cfg_run_mask_i;
   logic                    mem_ready_i;
   logic                    mem_valid_o;
   agu_req_t                mem_req_o;
   logic [NUM_CH-1:0]       done_o;

   int unsigned  lcg_state;
   int           timeout_cycles = 0;
   int           edge_cnt = 0;
   int           value_errs = 0;
   int           other_errs = 0;
   int           beats_seen = 0;
   agu_beat_t    exp_q [NUM_CH][$];
   agu_cfg_t     cfg_m [NUM_CH];
   int           run_edge [NUM_CH];
   // run edge of the sequence whose beats are now in the expected queue.
   int           seq_edge [NUM_CH];
   logic         done_due [NUM_CH];
   logic         stall_seen = 1'b0;
   agu_req_t     stall_req;
   logic         have_last = 1'b0;
   int           last_ch = 0;

   agu_top UUT (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cfg_we_i       (cfg_we_i),
      .cfg_ch_i       (cfg_ch_i),
      .cfg_field_i    (cfg_field_i),
      .cfg_data_i     (cfg_data_i),
      .cfg_run_i      (cfg_run_i),
      .cfg_run_mask_i (cfg_run_mask_i),
      .mem_ready_i    (mem_ready_i),
      .mem_valid_o    (mem_valid_o),
      .mem_req_o      (mem_req_o),
      .done_o         (done_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   function automatic int unsigned next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return (lcg_state >> 16) & 32'h7fff;
   endfunction

   // a zero count still runs its level once.
   function automatic int loop_count(input logic [ADDR_W-1:0] v);
      return (v == '0) ? 1 : int'(v);
   endfunction

   function automatic int beat_total(input agu_cfg_t cfg);
      int n;
      n = 1;
      for (int l = 0; l < NUM_LVL; l++) begin
         n = n * loop_count(cfg.lvl[l].period) * loop_count(cfg.lvl[l].iterations);
      end
      return n;
   endfunction

   function automatic agu_cfg_t random_cfg();
      agu_cfg_t cfg;
      cfg.start = ADDR_W'(next_random());
      cfg.duty  = PERIOD_W'(next_random() % 4);
      cfg.delay = DELAY_W'(next_random() % 8);
      for (int l = 0; l < NUM_LVL; l++) begin
         cfg.lvl[l].period     = PERIOD_W'(next_random() % 4);
         cfg.lvl[l].incr       = ADDR_W'(next_random());
         cfg.lvl[l].iterations = ADDR_W'(next_random() % 3);
         cfg.lvl[l].shift      = ADDR_W'(next_random());
      end
      return cfg;
   endfunction

   function automatic logic [CFG_FIELD_W-1:0] level_field(input int l, input logic [1:0] sub);
      return CFG_FIELD_W'(int'(FLD_LVL_BASE) + 4 * l + int'(sub));
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      value_errs++;
      $display("error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
   endtask

   task automatic report_other(input string msg);
      other_errs++;
      $display("failure at %0t: %s", $time, msg);
   endtask

   // expected beats from the nested loops; incr steps only inside the duty window.
   task automatic build_expected(input int c, input agu_cfg_t cfg);
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] b1;
      logic [ADDR_W-1:0] b2;
      agu_beat_t         beat;
      int                np [NUM_LVL];
      int                ni [NUM_LVL];
      exp_q[c].delete();
      for (int l = 0; l < NUM_LVL; l++) begin
         np[l] = loop_count(cfg.lvl[l].period);
         ni[l] = loop_count(cfg.lvl[l].iterations);
      end
      b2 = cfg.start;
      for (int i2 = 0; i2 < ni[2]; i2++) begin
         for (int p2 = 0; p2 < np[2]; p2++) begin
            b1 = b2;
            for (int i1 = 0; i1 < ni[1]; i1++) begin
               for (int p1 = 0; p1 < np[1]; p1++) begin
                  a = b1;
                  for (int i0 = 0; i0 < ni[0]; i0++) begin
                     for (int p0 = 0; p0 < np[0]; p0++) begin
                        beat.addr  = a;
                        beat.store = (p0 < int'(cfg.duty));
                        exp_q[c].push_back(beat);
                        if (p0 < np[0] - 1 && beat.store) begin
                           a = a + (cfg.lvl[0].incr << OFFSET_W);
                        end
                     end
                     a = a + (cfg.lvl[0].shift << OFFSET_W);
                  end
                  if (p1 < np[1] - 1) begin
                     b1 = b1 + (cfg.lvl[1].incr << OFFSET_W);
                  end
               end
               b1 = b1 + (cfg.lvl[1].shift << OFFSET_W);
            end
            if (p2 < np[2] - 1) begin
               b2 = b2 + (cfg.lvl[2].incr << OFFSET_W);
            end
         end
         b2 = b2 + (cfg.lvl[2].shift << OFFSET_W);
      end
   endtask

   // called shortly before each rising edge, when every output has settled.
   task automatic check_edge();
      agu_beat_t         exp;
      int                c;
      logic [NUM_CH-1:0] others;
      c      = int'(mem_req_o.ch);
      others = UUT.ch_valid & ~(NUM_CH'(1) << c);
      for (int k = 0; k < NUM_CH; k++) begin
         if (done_due[k]) begin
            assert (done_o[k]) else report_other("done did not rise on the last transfer");
            done_due[k] = 1'b0;
         end
      end
      if (stall_seen && mem_valid_o && c == int'(stall_req.ch)) begin
         assert (mem_req_o == stall_req)
            else report_value("mem_req_o", 32'(mem_req_o), 32'(stall_req));
      end
      stall_seen = mem_valid_o && !mem_ready_i;
      stall_req  = mem_req_o;
      if (mem_valid_o && mem_ready_i) begin
         beats_seen++;
         // on its run edge the channel restarts and drops the beat it showed.
         if (edge_cnt != run_edge[c]) begin
            assert (!done_o[c]) else report_other("done is high during a transfer");
            assert (edge_cnt - seq_edge[c] > loop_count(ADDR_W'(cfg_m[c].delay)))
               else report_other("transfer came before the start delay ran out");
            assert (exp_q[c].size() > 0) else report_other("transfer with no beat left");
            if (exp_q[c].size() > 0) begin
               exp = exp_q[c].pop_front();
               assert (mem_req_o.addr == exp.addr)
                  else report_value("mem_req_o.addr", 32'(mem_req_o.addr), 32'(exp.addr));
               assert (mem_req_o.store == exp.store)
                  else report_value("mem_req_o.store", 32'(mem_req_o.store), 32'(exp.store));
               done_due[c] = (exp_q[c].size() == 0);
            end
         end
         assert (!(have_last && last_ch == c && others != '0))
            else report_other("one channel got two beats in a row while another waited");
         have_last = 1'b1;
         last_ch   = c;
      end
      for (int k = 0; k < NUM_CH; k++) begin
         if (edge_cnt == run_edge[k]) begin
            build_expected(k, cfg_m[k]);
            seq_edge[k] = run_edge[k];
         end
      end
   endtask

   initial begin
      forever begin
         @(negedge clk_i);
         #40;
         edge_cnt++;
         if (!rst_i) begin
            check_edge();
         end
      end
   end

   initial begin
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge clk_i);
      $display("watchdog expired before the channels finished");
      $display("RESULT: FAIL");
      $finish;
   end

   task automatic tick();
      @(negedge clk_i);
      mem_ready_i = (next_random() % 4) != 0;
   endtask

   task automatic write_field(input int c, input logic [CFG_FIELD_W-1:0] field,
                              input logic [31:0] data);
      tick();
      cfg_we_i    = 1'b1;
      cfg_ch_i    = agu_ch_t'(c);
      cfg_field_i = field;
      cfg_data_i  = data;
      tick();
      cfg_we_i    = 1'b0;
   endtask

   task automatic load_cfg(input int c, input agu_cfg_t cfg);
      write_field(c, FLD_START, 32'(cfg.start));
      write_field(c, FLD_DUTY, 32'(cfg.duty));
      write_field(c, FLD_DELAY, 32'(cfg.delay));
      for (int l = 0; l < NUM_LVL; l++) begin
         write_field(c, level_field(l, FLD_PERIOD), 32'(cfg.lvl[l].period));
         write_field(c, level_field(l, FLD_INCR), 32'(cfg.lvl[l].incr));
         write_field(c, level_field(l, FLD_ITER), 32'(cfg.lvl[l].iterations));
         write_field(c, level_field(l, FLD_SHIFT), 32'(cfg.lvl[l].shift));
      end
      cfg_m[c] = cfg;
   endtask

   // the run pulse is registered once in the config block, so the channel sees it 2 edges on.
   task automatic launch(input logic [NUM_CH-1:0] mask);
      tick();
      cfg_run_i      = 1'b1;
      cfg_run_mask_i = mask;
      for (int c = 0; c < NUM_CH; c++) begin
         if (mask[c]) begin
            run_edge[c] = edge_cnt + 2;
         end
      end
      tick();
      cfg_run_i = 1'b0;
   endtask

   task automatic wait_idle();
      int pending;
      pending = 1;
      while (pending != 0) begin
         tick();
         pending = (done_o != '1 || mem_valid_o) ? 1 : 0;
         for (int c = 0; c < NUM_CH; c++) begin
            pending = pending + exp_q[c].size() + ((edge_cnt <= run_edge[c]) ? 1 : 0);
         end
      end
   endtask

   initial begin
      agu_cfg_t cfg_a;
      agu_cfg_t cfg_b;
      agu_cfg_t cfg_c;
      agu_cfg_t cfg_d;
      rst_i          = 1'b1;
      cfg_we_i       = 1'b0;
      cfg_ch_i       = '0;
      cfg_field_i    = '0;
      cfg_data_i     = '0;
      cfg_run_i      = 1'b0;
      cfg_run_mask_i = '0;
      mem_ready_i    = 1'b0;
      lcg_state      = 2388;
      for (int c = 0; c < NUM_CH; c++) begin
         run_edge[c] = 0;
         seq_edge[c] = 0;
         done_due[c] = 1'b0;
         cfg_m[c]    = '0;
      end
      cfg_a = random_cfg();
      cfg_b = random_cfg();
      cfg_c = random_cfg();
      cfg_d = random_cfg();
      // the restart test needs a sequence long enough to interrupt.
      cfg_d.lvl[0].period     = 4;
      cfg_d.lvl[0].iterations = 2;
      timeout_cycles = 20 * (beat_total(cfg_a) + beat_total(cfg_b) + beat_total(cfg_c) +
                             2 * beat_total(cfg_d)) + 800;
      repeat (10) @(negedge clk_i);
      rst_i = 1'b0;
      tick();
      assert (!mem_valid_o) else report_value("mem_valid_o", 32'(mem_valid_o), 32'h0);
      assert (done_o == '1) else report_value("done_o", 32'(done_o), 32'((1 << NUM_CH) - 1));

      load_cfg(0, cfg_a);
      launch(2'b01);
      wait_idle();

      load_cfg(0, cfg_b);
      load_cfg(1, cfg_c);
      launch(2'b11);
      wait_idle();

      load_cfg(1, cfg_d);
      launch(2'b10);
      while (edge_cnt <= run_edge[1] || exp_q[1].size() + 3 > beat_total(cfg_d)) begin
         tick();
      end
      launch(2'b10);
      wait_idle();
      tick();
      tick();

      $display("%0d transfers checked, %0d value errors, %0d other errors",
               beats_seen, value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
source/agu_cfg_pkg.sv
source/agu_port_pkg.sv
source/agu_config_regs.sv
source/agu_channel.sv
source/agu_merger.sv
source/agu_top.sv
tb/agu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for a failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module agu_tb -f vlog.f -o agu_sim \
   > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/agu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error, see sim.log"
   exit 1
fi
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failure"
exit 0
